// ==== build.f ====
uart_pkg.sv
uart_tx.sv
uart_rx.sv
rx_buffer.sv
uart_top.sv
uart_asserts.sv
tb_clkgen.sv
tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - uart_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - rx_buffer.sv
  - uart_top.sv
  - target: test
    files:
      - uart_asserts.sv
      - tb_clkgen.sv
      - tb_uart.sv

// ==== tb_uart.sv ====
// Directed tests of uart_top; serial timing follows uart_pkg and a watchdog caps the run time
`timescale 1ns/1ps
`default_nettype none

module tb_uart
    import uart_pkg::*;
();

    localparam int CLK_NS      = 10;
    localparam int FRAME_TICKS = BIT_TICKS * (1 + BYTE_BITS + (PARITY_MODE != PARITY_NONE)
                                 + STOP_BITS);
    // Frames per test are 1, 5, 4, 3, then FIFO_DEPTH + 2 for flow control
    localparam int N_FRAMES    = 1 + 5 + 4 + 3 + FIFO_DEPTH + 2;
    localparam int WATCHDOG_NS = 2 * N_FRAMES * FRAME_TICKS * CLK_NS + 10_000;

    logic       clk;
    logic       rst;
    logic       rx;
    logic       rts;
    logic       tx;
    logic       cts;
    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       rx_read;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rx_err;
    logic       rx_overrun;

    integer     seed = 32'hea771f09;
    int         mismatches = 0;
    int         failures = 0;
    int         err_pulses = 0;
    int         ovr_pulses = 0;
    uart_byte_t exp_q[$];       // Bytes expected from the receive buffer with the oldest in front

    tb_clkgen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    uart_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .rts        (rts),
        .tx         (tx),
        .cts        (cts),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_read    (rx_read),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_err     (rx_err),
        .rx_overrun (rx_overrun)
    );

    // Pulse counters sampled away from the active edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (rx_err)
            begin
                err_pulses++;
            end
            if (rx_overrun)
            begin
                ovr_pulses++;
            end
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch at %0t ns: %s expected 8'h%02h, got 8'h%02h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
        begin
            mismatches++;
            $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    ////////////////////
    // Line models
    ////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic logic parity_of(input uart_byte_t b);
        logic p;
        int   i;
        p = (PARITY_MODE == PARITY_ODD);    // Odd parity counts one extra
        for (i = 0; i < BYTE_BITS; i++)
        begin
            p = p ^ b[i];
        end
        return p;
    endfunction

    // Drives one frame on rx bit by bit from a falling edge
    task automatic send_frame(input uart_byte_t b, input logic bad_parity, input logic bad_stop);
        int i;
        rx = 1'b0;
        wait_cycles(BIT_TICKS);
        for (i = 0; i < BYTE_BITS; i++)
        begin
            rx = b[i];
            wait_cycles(BIT_TICKS);
        end
        if (PARITY_MODE != PARITY_NONE)
        begin
            rx = parity_of(b) ^ bad_parity;
            wait_cycles(BIT_TICKS);
        end
        for (i = 0; i < STOP_BITS; i++)
        begin
            rx = !(bad_stop && i == 0);     // Framing error on the first stop bit
            wait_cycles(BIT_TICKS);
        end
        rx = 1'b1;
    endtask

    task automatic send_random_frame(input logic expect_stored);
        uart_byte_t b;
        b = $random(seed);
        if (expect_stored)
        begin
            exp_q.push_back(b);
        end
        send_frame(b, 1'b0, 1'b0);
    endtask

    // Decodes one frame from tx at mid-bit points
    task automatic read_tx_frame(output uart_byte_t b);
        int waited;
        int i;
        waited = 0;
        b = '0;
        while (tx && waited < 4 * FRAME_TICKS)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx)
        begin
            report_failure("no start bit seen on tx");
            return;
        end
        wait_cycles(HALF_BIT_TICKS - 1);
        check_bit("tx start bit", 1'b0, tx);
        for (i = 0; i < BYTE_BITS; i++)
        begin
            wait_cycles(BIT_TICKS);
            b[i] = tx;
            check_bit("tx_ready", 1'b0, tx_ready);
        end
        if (PARITY_MODE != PARITY_NONE)
        begin
            wait_cycles(BIT_TICKS);
            check_bit("tx parity bit", parity_of(b), tx);
        end
        for (i = 0; i < STOP_BITS; i++)
        begin
            wait_cycles(BIT_TICKS);
            check_bit("tx stop bit", 1'b1, tx);
            check_bit("tx_ready", 1'b0, tx_ready);
        end
        waited = 0;
        while (!tx_ready && waited < BIT_TICKS)
        begin
            @(negedge clk);
            waited++;
        end
        if (!tx_ready)
        begin
            report_failure("tx_ready did not rise after the stop bit");
        end
    endtask

    // Holds tx_valid until the transmitter takes the byte
    task automatic offer_byte(input uart_byte_t b);
        int waited;
        waited = 0;
        tx_data  = b;
        tx_valid = 1'b1;
        while (!tx_ready && waited < 2 * FRAME_TICKS)
        begin
            @(negedge clk);
            waited++;
        end
        if (!tx_ready)
        begin
            report_failure("tx_ready stayed low, byte never accepted");
            return;
        end
        @(negedge clk);                     // Accepted at the edge just passed
        check_bit("tx_ready", 1'b0, tx_ready);
    endtask

    task automatic pop_byte(input uart_byte_t exp);
        int waited;
        waited = 0;
        while (!rx_valid && waited < FRAME_TICKS)
        begin
            @(negedge clk);
            waited++;
        end
        if (!rx_valid)
        begin
            report_failure("rx_valid did not rise for a received byte");
            return;
        end
        check_byte("rx_data", exp, rx_data);
        rx_read = 1'b1;
        @(negedge clk);
        rx_read = 1'b0;
    endtask

    task automatic drain_buffer();
        while (exp_q.size() > 0)
        begin
            pop_byte(exp_q.pop_front());
        end
        check_bit("rx_valid", 1'b0, rx_valid);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_tx_frame();
        uart_byte_t b;
        uart_byte_t got;
        b = $random(seed);
        fork
            begin
                offer_byte(b);
                tx_valid = 1'b0;
            end
            read_tx_frame(got);
        join
        check_byte("tx byte", b, got);
    endtask

    task automatic test_tx_back_to_back();
        uart_byte_t sent[5];
        uart_byte_t got[5];
        int         i;
        for (i = 0; i < 5; i++)
        begin
            sent[i] = $random(seed);
        end
        fork
            begin
                for (int k = 0; k < 5; k++)
                begin
                    offer_byte(sent[k]);    // tx_valid stays high between bytes
                end
                tx_valid = 1'b0;
            end
            begin
                for (int m = 0; m < 5; m++)
                begin
                    read_tx_frame(got[m]);
                end
            end
        join
        for (i = 0; i < 5; i++)
        begin
            check_byte("tx byte", sent[i], got[i]);
        end
    endtask

    task automatic test_receive();
        int err_base;
        int i;
        err_base = err_pulses;
        for (i = 0; i < 4; i++)
        begin
            send_random_frame(1'b1);
        end
        drain_buffer();
        check_count("rx_err pulses", err_base, err_pulses);
    endtask

    task automatic test_rx_errors();
        int err_base;
        err_base = err_pulses;
        send_frame(uart_byte_t'($random(seed)), 1'b1, 1'b0);
        wait_cycles(BIT_TICKS);
        check_count("rx_err pulses", err_base + 1, err_pulses);
        check_bit("rx_valid", 1'b0, rx_valid);
        send_frame(uart_byte_t'($random(seed)), 1'b0, 1'b1);
        wait_cycles(BIT_TICKS);             // Line back at mark before the next start
        check_count("rx_err pulses", err_base + 2, err_pulses);
        check_bit("rx_valid", 1'b0, rx_valid);
        send_random_frame(1'b1);
        drain_buffer();
        check_count("rx_err pulses", err_base + 2, err_pulses);
    endtask

    task automatic test_flow_control();
        int ovr_base;
        int i;
        ovr_base = ovr_pulses;
        rts = 1'b1;
        wait_cycles(2);
        check_bit("cts", 1'b1, cts);
        for (i = 0; i < CTS_LIMIT; i++)
        begin
            send_random_frame(1'b1);
        end
        wait_cycles(HALF_BIT_TICKS);
        check_bit("cts", !FLOW_CTRL_EN, cts);       // High without flow control as the buffer is not full
        pop_byte(exp_q.pop_front());
        wait_cycles(2);
        check_bit("cts", 1'b1, cts);
        rts = 1'b0;
        wait_cycles(2);
        check_bit("cts", !FLOW_CTRL_EN, cts);
        rts = 1'b1;
        while (exp_q.size() < FIFO_DEPTH)
        begin
            send_random_frame(1'b1);
        end
        send_random_frame(1'b0);            // No room left for this one
        wait_cycles(HALF_BIT_TICKS);
        check_count("rx_overrun pulses", ovr_base + 1, ovr_pulses);
        drain_buffer();
    endtask

    ////////////////////
    // Run control
    ////////////////////

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial
    begin
        rx       = 1'b1;
        rts      = 1'b1;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_read  = 1'b0;
        @(posedge clk);
        while (rst)
        begin
            @(posedge clk);
        end
        @(negedge clk);
        check_bit("tx", 1'b1, tx);
        check_bit("tx_ready", 1'b1, tx_ready);
        check_bit("rx_valid", 1'b0, rx_valid);
        check_bit("rx_err", 1'b0, rx_err);
        check_bit("rx_overrun", 1'b0, rx_overrun);
        test_tx_frame();
        test_tx_back_to_back();
        test_receive();
        test_rx_errors();
        test_flow_control();
        wait_cycles(4);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, dut0.asserts0.fail_count);
        if (mismatches == 0 && failures == 0 && dut0.asserts0.fail_count == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
// Free-running 10 ns clock; rst is high for the first 4 rising edges and drops on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);         // Released away from the active edge
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== uart_asserts.sv ====
// Protocol checks bound into uart_top; all but the reset check are off while rst is high
`timescale 1ns/1ps
`default_nettype none

module uart_asserts (
    input wire clk,
    input wire rst,
    input wire tx,
    input wire tx_ready,
    input wire cts,
    input wire rx_push,
    input wire rx_err,
    input wire rx_overrun
);

    int fail_count = 0;     // Failed checks so far

    // Idle transmitter keeps the line at mark
    tx_idle_high: assert property (@(posedge clk) disable iff (rst) tx_ready |-> tx)
        else
        begin
            $error("tx low while tx_ready is high");
            fail_count++;
        end

    rx_err_pulse: assert property (@(posedge clk) disable iff (rst) rx_err |=> !rx_err)
        else
        begin
            $error("rx_err high for more than one cycle");
            fail_count++;
        end

    overrun_pulse: assert property (@(posedge clk) disable iff (rst) rx_overrun |=> !rx_overrun)
        else
        begin
            $error("rx_overrun high for more than one cycle");
            fail_count++;
        end

    push_or_err: assert property (@(posedge clk) disable iff (rst) !(rx_push && rx_err))
        else
        begin
            $error("rx_push and rx_err high together");
            fail_count++;
        end

    ////////////////////
    // Reset state
    ////////////////////

    cts_after_reset: assert property (@(posedge clk) $fell(rst) |-> !cts)
        else
        begin
            $error("cts high in the first cycle after reset");
            fail_count++;
        end

endmodule

bind uart_top uart_asserts asserts0 (
    .clk        (clk),
    .rst        (rst),
    .tx         (tx),
    .tx_ready   (tx_ready),
    .cts        (cts),
    .rx_push    (rx_push),
    .rx_err     (rx_err),
    .rx_overrun (rx_overrun)
);

`default_nettype wire

// ==== uart_top.sv ====
// Serial port top; the peer should hold off sending while cts is low or bytes may be lost
`timescale 1ns/1ps
`default_nettype none

module uart_top
    import uart_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    // Serial peer
    input  wire             rx,
    input  wire             rts,
    output logic            tx,
    output logic            cts,
    // User transmit side
    input  wire uart_byte_t tx_data,
    input  wire             tx_valid,
    output logic            tx_ready,
    // User receive side
    input  wire             rx_read,
    output uart_byte_t      rx_data,
    output logic            rx_valid,
    output logic            rx_err,
    output logic            rx_overrun
);

    uart_byte_t rx_byte;    // Receiver to buffer
    logic       rx_push;

    uart_tx tx0 (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

    uart_rx rx0 (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rx_byte (rx_byte),
        .rx_push (rx_push),
        .rx_err  (rx_err)
    );

    rx_buffer buf0 (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .rx_push    (rx_push),
        .rx_read    (rx_read),
        .rts        (rts),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_overrun (rx_overrun),
        .cts        (cts)
    );

endmodule

`default_nettype wire

// ==== rx_buffer.sv ====
// Show-ahead receive FIFO; rx_data is valid only while rx_valid is high and pushes when full are lost
`timescale 1ns/1ps
`default_nettype none

module rx_buffer
    import uart_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire uart_byte_t rx_byte,
    input  wire             rx_push,
    input  wire             rx_read,
    input  wire             rts,
    output uart_byte_t      rx_data,
    output logic            rx_valid,
    output logic            rx_overrun,
    output logic            cts
);

    uart_byte_t mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    fifo_cnt_t  count;
    logic       full;
    logic       do_push;
    logic       do_pop;

    assign full     = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign rx_valid = (count != '0);
    assign rx_data  = mem[rd_ptr];      // Oldest byte shown ahead
    assign do_push  = rx_push && !full;
    assign do_pop   = rx_read && rx_valid;

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= rx_byte;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rx_overrun <= 1'b0;
            cts        <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at the power-of-two depth
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            rx_overrun <= rx_push && full;  // One pulse per lost byte

            // Clear to send only with headroom left
            if (FLOW_CTRL_EN)
            begin
                cts <= rts && (count < fifo_cnt_t'(CTS_LIMIT));
            end
            else
            begin
                cts <= !full;
            end
        end
    end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
// Receives 8-bit frames; only the first stop bit is checked, bad frames give rx_err and no byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         rx,
    output uart_byte_t  rx_byte,
    output logic        rx_push,
    output logic        rx_err
);

    enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_WAIT
    } state;

    logic       rx_meta;
    logic       rx_sync;
    tick_cnt_t  tick;
    logic [2:0] bit_idx;
    logic       par_acc;    // Running XOR of received data bits
    logic       par_err;
    logic       sample;     // Mid-bit point of a data, parity or stop bit

    assign sample = (tick == tick_cnt_t'(BIT_TICKS - 1));

    ////////////////////
    // Line synchronizer
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Data bits shift in from the top, so bit 0 ends up as the first one sent
    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && sample)
        begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= RX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
            par_acc <= 1'b0;
            par_err <= 1'b0;
            rx_push <= 1'b0;
            rx_err  <= 1'b0;
        end
        else
        begin
            rx_push <= 1'b0;
            rx_err  <= 1'b0;
            tick    <= (sample || state == RX_IDLE) ? '0 : tick + 1'b1;

            case (state)
                RX_IDLE:
                begin
                    if (!rx_sync)
                    begin
                        state <= RX_START;      // Falling edge seen
                    end
                end
                RX_START:
                begin
                    if (tick == tick_cnt_t'(HALF_BIT_TICKS - 1))
                    begin
                        tick    <= '0;          // Later samples fall mid-bit
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                        par_err <= 1'b0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // High here is a glitch
                    end
                end
                RX_DATA:
                begin
                    if (sample)
                    begin
                        par_acc <= par_acc ^ rx_sync;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'(BYTE_BITS - 1))
                        begin
                            state <= (PARITY_MODE != PARITY_NONE) ? RX_PARITY : RX_STOP;
                        end
                    end
                end
                RX_PARITY:
                begin
                    if (sample)
                    begin
                        // Even parity leaves no odd one out over data plus parity bit
                        par_err <= (par_acc ^ rx_sync) != (PARITY_MODE == PARITY_ODD);
                        state   <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    if (sample)
                    begin
                        if (rx_sync && !par_err)
                        begin
                            rx_push <= 1'b1;
                        end
                        else
                        begin
                            rx_err <= 1'b1;     // Parity or framing error
                        end
                        state <= RX_WAIT;
                    end
                end
                RX_WAIT:
                begin
                    if (rx_sync)
                    begin
                        state <= RX_IDLE;       // Line back at mark
                    end
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
// Sends one frame per accepted byte; tx_data and tx_valid must be held until tx_ready takes them
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire uart_byte_t tx_data,
    input  wire             tx_valid,
    output logic            tx_ready,
    output logic            tx
);

    enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } state;

    tick_cnt_t  tick;       // Clocks spent in the current bit
    logic [2:0] bit_idx;    // Data bit, or stop bit, being sent
    uart_byte_t data_q;
    logic       par_bit;
    logic       bit_end;

    assign tx_ready = (state == TX_IDLE);
    assign bit_end  = (tick == tick_cnt_t'(BIT_TICKS - 1));

    // Parity over the latched byte
    assign par_bit = (PARITY_MODE == PARITY_ODD) ? ~(^data_q) : ^data_q;

    always_ff @(posedge clk)
    begin
        if (tx_valid && tx_ready)
        begin
            data_q <= tx_data;      // Held for the whole frame
        end
    end

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= TX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;        // Line idles at mark
        end
        else
        begin
            if (state != TX_IDLE)
            begin
                tick <= bit_end ? '0 : tick + 1'b1;
            end

            case (state)
                TX_IDLE:
                begin
                    if (tx_valid)
                    begin
                        state <= TX_START;
                        tick  <= '0;
                        tx    <= 1'b0;          // Start bit
                    end
                end
                TX_START:
                begin
                    if (bit_end)
                    begin
                        bit_idx <= '0;
                        tx      <= data_q[0];
                        state   <= TX_DATA;
                    end
                end
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == 3'(BYTE_BITS - 1))
                        begin
                            bit_idx <= '0;
                            if (PARITY_MODE != PARITY_NONE)
                            begin
                                tx    <= par_bit;
                                state <= TX_PARITY;
                            end
                            else
                            begin
                                tx    <= 1'b1;
                                state <= TX_STOP;
                            end
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 3'd1;
                            tx      <= data_q[bit_idx + 3'd1];  // Next bit going up from the LSB
                        end
                    end
                end
                TX_PARITY:
                begin
                    if (bit_end)
                    begin
                        tx    <= 1'b1;
                        state <= TX_STOP;
                    end
                end
                TX_STOP:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == 3'(STOP_BITS - 1))
                        begin
                            state <= TX_IDLE;   // tx_ready rises next cycle
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                default:
                begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== uart_pkg.sv ====
// Shared UART settings; BIT_TICKS must be even and at least 4, FIFO_DEPTH must be a power of two
`default_nettype none

package uart_pkg;

    ////////////////////
    // Frame format
    ////////////////////

    typedef logic [7:0] uart_byte_t;            // One data byte with the LSB sent first

    localparam int BYTE_BITS = 8;               // Data bits per frame

    localparam logic [1:0] PARITY_NONE = 2'd0;
    localparam logic [1:0] PARITY_EVEN = 2'd1;  // Parity bit makes the count of ones even
    localparam logic [1:0] PARITY_ODD  = 2'd2;

    localparam logic [1:0] PARITY_MODE = PARITY_EVEN;

    localparam int STOP_BITS = 1;               // 1 or 2

    ////////////////////
    // Bit timing
    ////////////////////

    typedef logic [15:0] tick_cnt_t;            // Bit-period counter

    localparam int BIT_TICKS      = 16;         // Clocks per serial bit
    localparam int HALF_BIT_TICKS = BIT_TICKS / 2;

    ////////////////////
    // Receive buffer
    ////////////////////

    typedef logic [3:0] fifo_cnt_t;             // Holds 0 .. FIFO_DEPTH

    localparam int FIFO_DEPTH = 8;

    // CTS drops here so frames already on the line still fit
    localparam int CTS_LIMIT = 6;

    localparam logic FLOW_CTRL_EN = 1'b1;       // RTS/CTS handshake on

endpackage

`default_nettype wire
